//--- all.f
+incdir+.
dma_pkg.sv
dma_channel.sv
dma_arbiter.sv
dma_req_fifo.sv
dma_top.sv
tb_dma_top.sv

//--- dma_arbiter.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module dma_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  dma_pkg::chan_mask_t req_valid,
    input  dma_pkg::mem_req_t   reqs [`DMA_NUM_CHAN],
    input  logic                full,
    output dma_pkg::chan_mask_t grant,
    output logic                push,
    output dma_pkg::mem_req_t   push_req
);

    // one-hot, marks the channel with top priority
    dma_pkg::chan_mask_t              ptr;
    logic [2*`DMA_NUM_CHAN-1:0] req_dbl;
    logic [2*`DMA_NUM_CHAN-1:0] pick_dbl;
    dma_pkg::chan_mask_t              pick;

    //////////////////////////////
    // round robin pick
    //////////////////////////////

    // doubled request vector so the search wraps past the top channel
    assign req_dbl  = {req_valid, req_valid};
    // borrow from ptr stops at the first request at or above it
    assign pick_dbl = req_dbl & ~(req_dbl - {{`DMA_NUM_CHAN{1'b0}}, ptr});
    // fold both halves, at most one bit set
    assign pick     = pick_dbl[`DMA_NUM_CHAN-1:0]
                    | pick_dbl[2*`DMA_NUM_CHAN-1:`DMA_NUM_CHAN];

    // nothing granted while the fifo is full
    assign grant = full ? '0 : pick;
    assign push  = |grant;

    // request mux toward the fifo
    always_comb begin
        push_req = '0;
        for (int i = 0; i < `DMA_NUM_CHAN; i++) begin
            if (grant[i]) begin
                push_req = reqs[i];
            end
        end
    end

    //////////////////////////////
    // pointer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            ptr <= dma_pkg::chan_mask_t'(1);
        end else if (push) begin
            // channel after the granted one goes first next time
            ptr <= {grant[`DMA_NUM_CHAN-2:0], grant[`DMA_NUM_CHAN-1]};
        end
    end

endmodule

//--- dma_channel.sv
`timescale 1ns/10ps

module dma_channel #(
    parameter int CHAN_IDX = 0
) (
    input  logic              clk,
    input  logic              rst,
    // command side
    input  dma_pkg::dma_cmd_t cmd,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    // toward the arbiter
    output logic              req_valid,
    output dma_pkg::mem_req_t req,
    input  logic              grant,
    // routed memory response
    input  logic              rsp_valid,
    input  dma_pkg::data_t    rsp_data,
    // forwarding unit side
    output dma_pkg::fu_beat_t fu_beat,
    output logic              fu_valid,
    input  logic              fu_ready
);

    //////////////////////////////
    // state
    //////////////////////////////

    dma_pkg::chan_state_e state;
    // held copy of the accepted command
    dma_pkg::dma_cmd_t    cmd_q;
    // index of the beat being worked on
    dma_pkg::pkt_len_t    beat_idx;
    dma_pkg::pkt_len_t    beat_nxt;
    dma_pkg::addr_t       beat_addr;
    dma_pkg::chan_mask_t  own_id;

    assign beat_nxt  = beat_idx + 1'b1;
    // beat k reads base+k
    assign beat_addr = cmd_q.base + dma_pkg::addr_t'(beat_idx);
    // one-hot tag, used to route the response back here
    assign own_id    = dma_pkg::chan_mask_t'(1) << CHAN_IDX;

    //////////////////////////////
    // handshake outputs
    //////////////////////////////

    // new command only when idle
    assign cmd_ready = (state == dma_pkg::idle);
    // one read at a time, raised only in request
    assign req_valid = (state == dma_pkg::request);
    assign req       = '{addr: beat_addr, id: own_id};
    // beat held stable for the whole deliver state
    assign fu_valid  = (state == dma_pkg::deliver);

    //////////////////////////////
    // fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= dma_pkg::idle;
            beat_idx <= '0;
        end else begin
            case (state)
                dma_pkg::idle: begin
                    if (cmd_valid) begin
                        beat_idx <= '0;
                        // zero length finishes right here
                        if (cmd.len != '0) begin
                            state <= dma_pkg::request;
                        end
                    end
                end
                dma_pkg::request: begin
                    // grant means the fifo took the request
                    if (grant) begin
                        state <= dma_pkg::wait_rsp;
                    end
                end
                dma_pkg::wait_rsp: begin
                    if (rsp_valid) begin
                        state <= dma_pkg::deliver;
                    end
                end
                dma_pkg::deliver: begin
                    if (fu_ready) begin
                        // last beat gone, back to idle
                        if (beat_nxt == cmd_q.len) begin
                            state <= dma_pkg::idle;
                        end else begin
                            beat_idx <= beat_nxt;
                            state    <= dma_pkg::request;
                        end
                    end
                end
                default: begin
                    state <= dma_pkg::idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // payload capture
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_valid) begin
            cmd_q <= cmd;
        end
        // response lands in the held beat, ids echoed from the command
        if ((state == dma_pkg::wait_rsp) && rsp_valid) begin
            fu_beat <= '{proc_id:  cmd_q.proc_id,
                         slot_id:  cmd_q.slot_id,
                         addr:     beat_addr,
                         data:     rsp_data,
                         tx_count: beat_idx};
        end
    end

endmodule

//--- dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

//////////////////////////////
// channel count
//////////////////////////////

`define DMA_NUM_CHAN 4

//////////////////////////////
// field widths
//////////////////////////////

// word address, not byte address
`define DMA_ADDR_W 32
`define DMA_DATA_W 64
`define DMA_PROC_W 7
`define DMA_SLOT_W 7
// packet length and transfer count share this width
`define DMA_PKT_W 13

// request fifo in front of the memory port
`define DMA_FIFO_DEPTH 4

`endif

//--- dma_pkg.sv
`include "dma_consts.svh"

package dma_pkg;

    //////////////////////////////
    // plain vectors
    //////////////////////////////

    typedef logic [`DMA_ADDR_W-1:0]   addr_t;
    typedef logic [`DMA_DATA_W-1:0]   data_t;
    typedef logic [`DMA_PROC_W-1:0]   proc_id_t;
    typedef logic [`DMA_SLOT_W-1:0]   slot_id_t;
    typedef logic [`DMA_PKT_W-1:0]    pkt_len_t;
    // one bit per channel, one-hot when used as an id
    typedef logic [`DMA_NUM_CHAN-1:0] chan_mask_t;

    //////////////////////////////
    // bundles
    //////////////////////////////

    // read command from the command decoder
    typedef struct packed {
        addr_t    base;
        proc_id_t proc_id;
        slot_id_t slot_id;
        pkt_len_t len;
    } dma_cmd_t;

    // one word read, tagged with the asking channel
    typedef struct packed {
        addr_t      addr;
        chan_mask_t id;
    } mem_req_t;

    // one beat toward the forwarding unit
    typedef struct packed {
        proc_id_t proc_id;
        slot_id_t slot_id;
        addr_t    addr;
        data_t    data;
        pkt_len_t tx_count;
    } fu_beat_t;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_rsp,
        deliver
    } chan_state_e;

endpackage

//--- dma_req_fifo.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module dma_req_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  dma_pkg::mem_req_t push_req,
    input  logic              pop,
    output logic              full,
    output dma_pkg::mem_req_t head,
    output logic              not_empty
);

    localparam int PTR_W = $clog2(`DMA_FIFO_DEPTH);

    // storage
    dma_pkg::mem_req_t mem [`DMA_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    // one extra bit to tell full from empty
    logic [PTR_W:0]    count;
    logic              wr_en;
    logic              rd_en;

    assign full      = (count == (PTR_W + 1)'(`DMA_FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // drop anything that would overflow or underflow
    assign wr_en = push && !full;
    assign rd_en = pop && not_empty;

    //////////////////////////////
    // pointers and count
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`DMA_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(`DMA_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_req;
        end
    end

endmodule

//--- dma_top.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module dma_top (
    input  logic                clk,
    input  logic                rst,
    // command ports, one per channel
    input  dma_pkg::dma_cmd_t   cmd [`DMA_NUM_CHAN],
    input  dma_pkg::chan_mask_t cmd_valid,
    output dma_pkg::chan_mask_t cmd_ready,
    // forwarding unit ports
    output dma_pkg::fu_beat_t   fu_beat [`DMA_NUM_CHAN],
    output dma_pkg::chan_mask_t fu_valid,
    input  dma_pkg::chan_mask_t fu_ready,
    // shared memory request port
    output dma_pkg::mem_req_t   mem_req,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    // shared memory response port, always accepted
    input  logic                mem_rsp_valid,
    input  dma_pkg::chan_mask_t mem_rsp_id,
    input  dma_pkg::data_t      mem_rsp_data
);

    //////////////////////////////
    // internal wiring
    //////////////////////////////

    dma_pkg::chan_mask_t chan_req_valid;
    dma_pkg::mem_req_t   chan_reqs [`DMA_NUM_CHAN];
    dma_pkg::chan_mask_t grant;
    dma_pkg::chan_mask_t rsp_valid;
    logic                push;
    dma_pkg::mem_req_t   push_req;
    logic                fifo_full;

    // response goes only to the channel named by the id
    assign rsp_valid = {`DMA_NUM_CHAN{mem_rsp_valid}} & mem_rsp_id;

    for (genvar i = 0; i < `DMA_NUM_CHAN; i++) begin : g_chan
        dma_channel #(
            .CHAN_IDX (i)
        ) u_chan (
            .clk       (clk),
            .rst       (rst),
            .cmd       (cmd[i]),
            .cmd_valid (cmd_valid[i]),
            .cmd_ready (cmd_ready[i]),
            .req_valid (chan_req_valid[i]),
            .req       (chan_reqs[i]),
            .grant     (grant[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp_data  (mem_rsp_data),
            .fu_beat   (fu_beat[i]),
            .fu_valid  (fu_valid[i]),
            .fu_ready  (fu_ready[i])
        );
    end

    dma_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .req_valid (chan_req_valid),
        .reqs      (chan_reqs),
        .full      (fifo_full),
        .grant     (grant),
        .push      (push),
        .push_req  (push_req)
    );

    // fifo head drives the memory port directly
    dma_req_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_req  (push_req),
        .pop       (mem_req_ready),
        .full      (fifo_full),
        .head      (mem_req),
        .not_empty (mem_req_valid)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the dma testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_dma_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dma_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- tb_dma_top.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module tb_dma_top;

    localparam int NCH = `DMA_NUM_CHAN;
    // the tests take under 1000 cycles so this leaves a 4x margin
    localparam int unsigned MAX_CYCLES = 4000;

    logic                clk;
    logic                rst;
    dma_pkg::dma_cmd_t   cmd [NCH];
    dma_pkg::chan_mask_t cmd_valid;
    dma_pkg::chan_mask_t cmd_ready;
    dma_pkg::fu_beat_t   fu_beat [NCH];
    dma_pkg::chan_mask_t fu_valid;
    dma_pkg::chan_mask_t fu_ready;
    dma_pkg::mem_req_t   mem_req;
    logic                mem_req_valid;
    logic                mem_req_ready;
    logic                mem_rsp_valid = 1'b0;
    dma_pkg::chan_mask_t mem_rsp_id = '0;
    dma_pkg::data_t      mem_rsp_data = '0;

    // pending memory answer due at a given cycle
    typedef struct packed {
        int unsigned       due;
        dma_pkg::mem_req_t req;
    } pend_t;

    pend_t               pend [$];
    // every request the memory accepted in order
    dma_pkg::mem_req_t   req_log [$];
    // beats still expected per channel
    dma_pkg::fu_beat_t   exp_q [NCH][$];
    dma_pkg::fu_beat_t   held [NCH];
    dma_pkg::chan_mask_t held_v = '0;
    int unsigned         cycle = 0;
    int                  beat_errs = 0;
    int                  req_errs;
    int                  other_errs;

    dma_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_beat(input dma_pkg::fu_beat_t got, input dma_pkg::fu_beat_t exp,
                              input string what);
        if (got !== exp) begin
            beat_errs++;
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_req(input dma_pkg::mem_req_t got, input dma_pkg::mem_req_t exp,
                             input string what);
        if (got !== exp) begin
            req_errs++;
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input dma_pkg::chan_mask_t got, input dma_pkg::chan_mask_t exp,
                              input string what);
        if (got !== exp) begin
            other_errs++;
            $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            other_errs++;
            $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////

    // answers come in order and at most one per cycle
    // latency is 1 to 4 cycles after the pop
    always @(posedge clk) begin
        int unsigned due;
        if (!rst) begin
            pend.delete();
            mem_rsp_valid <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                req_log.push_back(mem_req);
                due = cycle + $urandom_range(1, 4);
                // never before the answer ahead of it
                if (pend.size() != 0 && due <= pend[$].due) begin
                    due = pend[$].due + 1;
                end
                pend.push_back('{due: due, req: mem_req});
            end
            if (pend.size() != 0 && pend[0].due <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_id    <= pend[0].req.id;
                // data is the address and its inverse
                mem_rsp_data  <= {pend[0].req.addr, ~pend[0].req.addr};
                void'(pend.pop_front());
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // beat monitor
    //////////////////////////////

    always @(posedge clk) begin
        dma_pkg::fu_beat_t exp;
        if (!rst) begin
            held_v = '0;
        end
        for (int ch = 0; ch < NCH; ch++) begin
            if (rst && fu_valid[ch]) begin
                // stalled beat must not move
                if (held_v[ch]) begin
                    check_beat(fu_beat[ch], held[ch], $sformatf("held beat ch%0d", ch));
                end
                if (fu_ready[ch]) begin
                    held_v[ch] = 1'b0;
                    if (exp_q[ch].size() == 0) begin
                        beat_errs++;
                        $display("channel %0d forwarded a beat nobody asked for", ch);
                    end else begin
                        exp = exp_q[ch].pop_front();
                        check_beat(fu_beat[ch], exp, $sformatf("beat ch%0d", ch));
                    end
                end else begin
                    held[ch]   = fu_beat[ch];
                    held_v[ch] = 1'b1;
                end
            end else if (rst && held_v[ch]) begin
                // valid has to stay up until the beat is taken
                beat_errs++;
                $display("channel %0d dropped fu_valid before fu_ready", ch);
                held_v[ch] = 1'b0;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic apply_reset();
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_mask(cmd_ready, '1, "cmd_ready after reset");
        check_mask(fu_valid, '0, "fu_valid after reset");
        check_bit(mem_req_valid, 1'b0, "mem_req_valid after reset");
    endtask

    // drives one command and queues its beats
    // caller sits on a rising edge
    task automatic load_cmd(input int ch, input dma_pkg::addr_t base, input dma_pkg::pkt_len_t len,
                            input dma_pkg::proc_id_t pid, input dma_pkg::slot_id_t sid);
        dma_pkg::addr_t a;
        cmd[ch]       <= '{base: base, proc_id: pid, slot_id: sid, len: len};
        cmd_valid[ch] <= 1'b1;
        // beat k reads base+k and counts k
        for (int k = 0; k < int'(len); k++) begin
            a = base + dma_pkg::addr_t'(k);
            exp_q[ch].push_back('{proc_id: pid, slot_id: sid, addr: a, data: {a, ~a},
                                  tx_count: dma_pkg::pkt_len_t'(k)});
        end
    endtask

    // idle channels take the commands at the next edge
    task automatic fire_cmds();
        @(posedge clk);
        cmd_valid <= '0;
    endtask

    task automatic wait_drained();
        int left;
        do begin
            @(negedge clk);
            left = 0;
            for (int ch = 0; ch < NCH; ch++) begin
                left += exp_q[ch].size();
            end
        end while (left != 0);
        check_mask(cmd_ready, '1, "cmd_ready after last beat");
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic single_read();
        @(posedge clk);
        load_cmd(0, 32'h0000_1000, 13'd5, 7'd11, 7'd21);
        fire_cmds();
        wait_drained();
    endtask

    task automatic fu_backpressure();
        @(posedge clk);
        load_cmd(2, 32'h0000_2000, 13'd8, 7'd12, 7'd22);
        fu_ready[2] <= 1'b0;
        fire_cmds();
        @(negedge clk);
        // random ready until every beat is through
        while (exp_q[2].size() != 0) begin
            @(posedge clk);
            fu_ready[2] <= 1'($urandom_range(0, 1));
            @(negedge clk);
        end
        @(posedge clk);
        fu_ready[2] <= 1'b1;
        wait_drained();
    endtask

    task automatic arbitration_order();
        int log_base;
        @(posedge clk);
        apply_reset();
        log_base = req_log.size();
        @(posedge clk);
        mem_req_ready <= 1'b0;
        for (int ch = 0; ch < NCH; ch++) begin
            load_cmd(ch, 32'h3000 + 32'h100 * ch, 13'd1, 7'(30 + ch), 7'(40 + ch));
        end
        fire_cmds();
        // fifo fills while the port is stalled
        repeat (6) @(posedge clk);
        mem_req_ready <= 1'b1;
        do @(negedge clk); while (req_log.size() < log_base + NCH);
        for (int ch = 0; ch < NCH; ch++) begin
            check_req(req_log[log_base + ch],
                      '{addr: 32'h3000 + 32'h100 * ch, id: dma_pkg::chan_mask_t'(1 << ch)},
                      $sformatf("request %0d after reset", ch));
        end
        wait_drained();
    endtask

    task automatic concurrent_channels();
        int lens [NCH] = '{3, 7, 2, 5};
        @(posedge clk);
        for (int ch = 0; ch < NCH; ch++) begin
            load_cmd(ch, 32'h4000 + 32'h1000 * ch, dma_pkg::pkt_len_t'(lens[ch]),
                     7'(50 + ch), 7'(60 + ch));
        end
        fire_cmds();
        wait_drained();
    endtask

    task automatic zero_length();
        int log_base;
        log_base = req_log.size();
        @(posedge clk);
        load_cmd(1, 32'h0000_9000, 13'd0, 7'd15, 7'd25);
        fire_cmds();
        @(negedge clk);
        check_mask(cmd_ready, '1, "cmd_ready after zero-length command");
        // quiet window for a stray request
        repeat (4) @(negedge clk);
        if (req_log.size() != log_base || mem_req_valid) begin
            other_errs++;
            $display("zero-length command issued a memory request");
        end
    endtask

    initial begin
        void'($urandom(56942));
        rst           = 1'b0;
        cmd_valid     = '0;
        fu_ready      = '1;
        mem_req_ready = 1'b1;
        req_errs      = 0;
        other_errs    = 0;
        for (int ch = 0; ch < NCH; ch++) begin
            cmd[ch] = '0;
        end
        apply_reset();
        single_read();
        fu_backpressure();
        arbitration_order();
        concurrent_channels();
        zero_length();
        $display("errors: %0d beat, %0d request, %0d other", beat_errs, req_errs, other_errs);
        if (beat_errs + req_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
